// ==== i2s_pkg.sv ====
`default_nettype none

package i2s_pkg;

    // system clocks per stereo frame (mclk / lrclk)
    localparam int MCLK_LRCK_RATIO = 128;
    // sclk periods per stereo frame
    localparam int SCLK_LRCLK_RATIO = 64;
    // bits per channel sample
    localparam int DATA_BIT = 16;

    // divider covers one full lrclk period, msb is lrclk
    localparam int DVSR_WIDTH = $clog2(MCLK_LRCK_RATIO);
    // one counter value per sclk slot of the frame
    localparam int SLOT_WIDTH = $clog2(SCLK_LRCLK_RATIO);
    // index into one channel sample
    localparam int BIT_WIDTH = $clog2(DATA_BIT);

    // one channel, two's complement
    typedef logic signed [DATA_BIT-1:0] i2s_sample_t;

    // stereo frame, left sits in the upper half
    typedef struct packed {
        i2s_sample_t left;
        i2s_sample_t right;
    } i2s_frame_t;

    // descriptor of the slot currently on the serial line
    typedef struct packed {
        // one clock at the top of the frame
        logic                 start;
        // one clock after the last slot, load strobe for tx
        logic                 finish;
        // sample bit addressed by this slot, zero in padding
        logic [BIT_WIDTH-1:0] count;
        // slot carries payload
        logic                 count_valid;
        // slot belongs to the left channel
        logic                 count_left;
        // current sclk level
        logic                 sclk;
    } i2s_slot_t;

endpackage

`default_nettype wire

// ==== i2s_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_clk (
    input  wire logic               i_clk_12_288,
    input  wire logic               i_reset_n,
    output logic                    o_mclk,
    output logic                    o_sclk,
    output logic                    o_lrclk,
    output i2s_pkg::i2s_slot_t      o_slot
);

    // free running divider
    // bit 0 is sclk (6.144 MHz), msb is lrclk (96 kHz)
    logic [i2s_pkg::DVSR_WIDTH-1:0] clk_divider;

    // slot counter, runs 63 down to 0 and wraps
    logic [i2s_pkg::SLOT_WIDTH-1:0] s_reg;
    logic                           s_start;
    logic                           s_finish;

    logic                           sclk;
    logic                           b_valid;

    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            clk_divider <= '0;
        end else begin
            clk_divider <= clk_divider + 1'b1;
        end
    end

    assign sclk = clk_divider[0];

    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            s_reg    <= '0;
            s_start  <= 1'b0;
            s_finish <= 1'b0;
        end else begin
            // one step per sclk period, taken on the sclk-high clock
            if (sclk) begin
                s_reg <= s_reg - 1'b1;
            end
            // each counter value lasts two clocks
            // so the pulses are guarded against a second high clock
            s_start  <= !s_start && (s_reg == '1);
            s_finish <= !s_finish && (s_reg == '0);
        end
    end

    // upper counter bit set means left half of the frame
    // note that this is the inverse of the lrclk level
    assign o_slot.count_left = s_reg[i2s_pkg::SLOT_WIDTH-1];

    // only the first DATA_BIT slots of each half carry payload
    assign b_valid = s_reg[i2s_pkg::BIT_WIDTH];
    assign o_slot.count_valid = b_valid;

    // bit index follows the counter, msb first
    assign o_slot.count = b_valid ? s_reg[i2s_pkg::BIT_WIDTH-1:0] : '0;

    assign o_slot.start  = s_start;
    assign o_slot.finish = s_finish;
    assign o_slot.sclk   = sclk;

    // mclk is the system clock itself
    assign o_mclk  = i_clk_12_288;
    assign o_sclk  = sclk;
    assign o_lrclk = clk_divider[i2s_pkg::DVSR_WIDTH-1];

endmodule

`default_nettype wire

// ==== i2s_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_tx (
    input  wire logic                i_clk_12_288,
    input  wire logic                i_reset_n,
    input  wire i2s_pkg::i2s_slot_t  i_slot,
    input  wire i2s_pkg::i2s_frame_t i_frame,
    output logic                     o_sdata
);

    // frame being shifted out during the current lrclk period
    i2s_pkg::i2s_frame_t frame_reg;

    // channel addressed by the slot
    i2s_pkg::i2s_sample_t chan_sample;

    logic next_bit;

    // new frame taken on the finish strobe
    // it goes out starting with the next slot 63
    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            frame_reg <= '0;
        end else if (i_slot.finish) begin
            frame_reg <= i_frame;
        end
    end

    assign chan_sample = i_slot.count_left ? frame_reg.left : frame_reg.right;

    // padding slots send zero
    assign next_bit = i_slot.count_valid ? chan_sample[i_slot.count] : 1'b0;

    // registered output
    // slot decoded on its sclk-low clock shows up on its sclk-high clock
    // which is where the receiver samples
    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_sdata <= 1'b0;
        end else begin
            o_sdata <= next_bit;
        end
    end

endmodule

`default_nettype wire

// ==== i2s_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_rx (
    input  wire logic                i_clk_12_288,
    input  wire logic                i_reset_n,
    input  wire i2s_pkg::i2s_slot_t  i_slot,
    input  wire logic                i_sdata,
    output i2s_pkg::i2s_frame_t      o_frame,
    output logic                     o_valid
);

    // frame under assembly, each payload bit lands in its own position
    i2s_pkg::i2s_frame_t asm_frame;

    logic sample_en;

    // sample once per slot, on the sclk-high clock of payload slots
    assign sample_en = i_slot.count_valid && i_slot.sclk;

    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            asm_frame <= '0;
        end else if (sample_en) begin
            if (i_slot.count_left) begin
                asm_frame.left[i_slot.count] <= i_sdata;
            end else begin
                asm_frame.right[i_slot.count] <= i_sdata;
            end
        end
    end

    // hand over at frame finish
    // all 32 payload slots are done by then, no clear needed
    // since every bit gets rewritten in the next frame
    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_frame <= '0;
        end else if (i_slot.finish) begin
            o_frame <= asm_frame;
        end
    end

    // valid rises together with the new o_frame, lasts one clock
    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_slot.finish;
        end
    end

endmodule

`default_nettype wire

// ==== i2s_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_top (
    input  wire logic                i_clk_12_288,
    input  wire logic                i_reset_n,
    input  wire i2s_pkg::i2s_frame_t i_tx_frame,
    input  wire logic                i_sdata,
    output logic                     o_mclk,
    output logic                     o_sclk,
    output logic                     o_lrclk,
    output logic                     o_sdata,
    output logic                     o_tx_load,
    output i2s_pkg::i2s_frame_t      o_rx_frame,
    output logic                     o_rx_valid
);

    // slot descriptor shared by both directions
    i2s_pkg::i2s_slot_t slot;

    i2s_clk u_clk (
        .i_clk_12_288 (i_clk_12_288),
        .i_reset_n    (i_reset_n),
        .o_mclk       (o_mclk),
        .o_sclk       (o_sclk),
        .o_lrclk      (o_lrclk),
        .o_slot       (slot)
    );

    i2s_tx u_tx (
        .i_clk_12_288 (i_clk_12_288),
        .i_reset_n    (i_reset_n),
        .i_slot       (slot),
        .i_frame      (i_tx_frame),
        .o_sdata      (o_sdata)
    );

    i2s_rx u_rx (
        .i_clk_12_288 (i_clk_12_288),
        .i_reset_n    (i_reset_n),
        .i_slot       (slot),
        .i_sdata      (i_sdata),
        .o_frame      (o_rx_frame),
        .o_valid      (o_rx_valid)
    );

    // source sees when i_tx_frame was taken
    assign o_tx_load = slot.finish;

endmodule

`default_nettype wire

// ==== i2s_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_checker (
    input wire logic               i_clk_12_288,
    input wire logic               i_reset_n,
    input wire i2s_pkg::i2s_slot_t i_slot
);

    // clocks since the last start pulse
    logic [i2s_pkg::DVSR_WIDTH-1:0] since_start;
    // period check only makes sense once a first start was seen
    logic                           seen_start;
    // read by the testbench at the end of the run
    int                             fail_count = 0;

    always_ff @(posedge i_clk_12_288, negedge i_reset_n) begin
        if (!i_reset_n) begin
            since_start <= '0;
            seen_start  <= 1'b0;
        end else if (i_slot.start) begin
            since_start <= '0;
            seen_start  <= 1'b1;
        end else begin
            since_start <= since_start + 1'b1;
        end
    end

    // pulses are a single clock wide
    start_single: assert property (@(posedge i_clk_12_288) disable iff (!i_reset_n)
        i_slot.start |=> !i_slot.start)
    else begin
        fail_count = fail_count + 1;
        $error("start pulse held for two clocks");
    end

    finish_single: assert property (@(posedge i_clk_12_288) disable iff (!i_reset_n)
        i_slot.finish |=> !i_slot.finish)
    else begin
        fail_count = fail_count + 1;
        $error("finish pulse held for two clocks");
    end

    // next start exactly one frame (128 clocks) later, never earlier
    start_period: assert property (@(posedge i_clk_12_288) disable iff (!i_reset_n)
        seen_start |-> (i_slot.start == (since_start == 7'd127)))
    else begin
        fail_count = fail_count + 1;
        $error("start pulse not 128 clocks after the previous one");
    end

    // padding slots carry no bit index
    pad_count: assert property (@(posedge i_clk_12_288) disable iff (!i_reset_n)
        !i_slot.count_valid |-> (i_slot.count == '0))
    else begin
        fail_count = fail_count + 1;
        $error("nonzero bit index in a padding slot");
    end

endmodule

bind i2s_clk i2s_checker u_checker (
    .i_clk_12_288 (i_clk_12_288),
    .i_reset_n    (i_reset_n),
    .i_slot       (o_slot)
);

`default_nettype wire

// ==== tb_i2s.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2s;

    localparam int NUM_FRAMES  = 40;
    localparam int FRAME_CLKS  = i2s_pkg::MCLK_LRCK_RATIO;
    // four spare frames on top of the run, 4 ns per clock
    localparam int WATCHDOG_NS = (NUM_FRAMES + 4) * FRAME_CLKS * 4;
    localparam int T_RESET     = 0;
    localparam int T_CLOCKS    = 1;
    localparam int T_LOAD      = 2;
    localparam int T_LOOP      = 3;
    localparam int T_SERIAL    = 4;
    localparam int NUM_TESTS   = 5;

    logic                clk_12_288 = 1'b0;
    logic                reset_n = 1'b0;
    i2s_pkg::i2s_frame_t tx_frame;
    logic                sdata;
    logic                mclk;
    logic                sclk;
    logic                lrclk;
    logic                tx_load;
    i2s_pkg::i2s_frame_t rx_frame;
    logic                rx_valid;

    integer seed;
    string  test_name [NUM_TESTS];
    int     checks [NUM_TESTS];
    int     errors [NUM_TESTS];

    // reference model state, one entry per load strobe
    i2s_pkg::i2s_frame_t load_frames [$];
    int                  load_cycles [$];
    // clocks since reset release, 0 is the release edge
    int   cycle = -1;
    int   rx_count = 0;
    logic load_seen = 1'b0;
    logic prev_sclk;
    logic prev_lrclk;
    int   last_lr_toggle;
    // mclk rising edges since the previous falling system clock edge
    int   mclk_rises = 0;

    // serial line looped straight back
    i2s_top dut (
        .i_clk_12_288 (clk_12_288),
        .i_reset_n    (reset_n),
        .i_tx_frame   (tx_frame),
        .i_sdata      (sdata),
        .o_mclk       (mclk),
        .o_sclk       (sclk),
        .o_lrclk      (lrclk),
        .o_sdata      (sdata),
        .o_tx_load    (tx_load),
        .o_rx_frame   (rx_frame),
        .o_rx_valid   (rx_valid)
    );

    always #2 clk_12_288 = ~clk_12_288;

    always @(posedge mclk) begin
        mclk_rises = mclk_rises + 1;
    end

    task automatic mark_check(int t);
        checks[t] = checks[t] + 1;
    endtask

    task automatic fail_value(int t, string what, logic [31:0] exp, logic [31:0] act);
        errors[t] = errors[t] + 1;
        $display("[FAIL] %s: %s expected %h actual %h at cycle %0d",
                 test_name[t], what, exp, act, cycle);
    endtask

    task automatic fail_event(int t, string what);
        errors[t] = errors[t] + 1;
        $display("error in %s: %s at cycle %0d", test_name[t], what, cycle);
    endtask

    task automatic print_result(int t);
        if (errors[t] == 0 && checks[t] > 0) begin
            $display("result %s: ok, %0d checks", test_name[t], checks[t]);
        end else begin
            $display("result %s: %0d errors in %0d checks", test_name[t], errors[t], checks[t]);
        end
    endtask

    // frame on the line, by slot position after start
    // 0..15 left msb first, 32..47 right msb first, the rest is padding
    function automatic logic expected_bit(i2s_pkg::i2s_frame_t frame, int pos);
        logic [3:0] idx;
        idx = 4'(15 - (pos % 16));
        if (pos < 16) return frame.left[idx];
        if (pos >= 32 && pos < 48) return frame.right[idx];
        return 1'b0;
    endfunction

    task automatic check_reset_outputs();
        logic [4:0] outs;
        outs = {sclk, lrclk, sdata, tx_load, rx_valid};
        mark_check(T_RESET);
        if (outs !== 5'b0) fail_value(T_RESET, "sclk,lrclk,sdata,load,valid", 32'h0, 32'(outs));
    endtask

    task automatic check_clocks();
        // mclk rises exactly once per system clock
        mark_check(T_CLOCKS);
        if (mclk_rises != 1) fail_value(T_CLOCKS, "mclk rising edges", 1, mclk_rises);
        mclk_rises = 0;
        mark_check(T_CLOCKS);
        if (sclk === prev_sclk) fail_event(T_CLOCKS, "sclk did not toggle");
        if (lrclk !== prev_lrclk) begin
            mark_check(T_CLOCKS);
            if (cycle - last_lr_toggle != FRAME_CLKS / 2) begin
                fail_value(T_CLOCKS, "lrclk half period", FRAME_CLKS / 2, cycle - last_lr_toggle);
            end
            last_lr_toggle = cycle;
        end else if (cycle - last_lr_toggle > FRAME_CLKS / 2) begin
            fail_event(T_CLOCKS, "lrclk held past its half period");
            last_lr_toggle = cycle;
        end
        prev_sclk  = sclk;
        prev_lrclk = lrclk;
    endtask

    task automatic check_serial();
        int   n;
        int   pos;
        logic exp_bit;
        n = load_cycles.size();
        // bits are stable on the sclk-high clock, slot pos sits at clock 2*pos+2
        if (sclk && n > 0) begin
            pos = (cycle - load_cycles[n-1] - 2) / 2;
            mark_check(T_SERIAL);
            if (pos > 63) begin
                fail_event(T_SERIAL, "no load strobe for more than a frame");
            end else begin
                exp_bit = expected_bit(load_frames[n-1], pos);
                if (sdata !== exp_bit) begin
                    fail_value(T_SERIAL, $sformatf("slot %0d", pos), 32'(exp_bit), 32'(sdata));
                end
            end
        end
    endtask

    task automatic track_load();
        int n;
        n = load_cycles.size();
        if (tx_load) begin
            if (n > 0) begin
                mark_check(T_LOAD);
                if (cycle - load_cycles[n-1] != FRAME_CLKS) begin
                    fail_value(T_LOAD, "load spacing", FRAME_CLKS, cycle - load_cycles[n-1]);
                end
            end
            load_frames.push_back(tx_frame);
            load_cycles.push_back(cycle);
        end
    endtask

    task automatic check_rx();
        i2s_pkg::i2s_frame_t exp_frame;
        int                  n;
        n = load_cycles.size();
        exp_frame = '0;
        if (rx_valid) begin
            mark_check(T_LOOP);
            // frame of the load before the latest one, zeros before that
            if (n >= 2) begin
                exp_frame = load_frames[n-2];
                mark_check(T_LOOP);
                if (cycle - load_cycles[n-2] != FRAME_CLKS + 1) begin
                    fail_value(T_LOOP, "load to valid clocks", FRAME_CLKS + 1,
                               cycle - load_cycles[n-2]);
                end
            end
            if (rx_frame !== exp_frame) begin
                fail_value(T_LOOP, $sformatf("rx frame %0d", rx_count), exp_frame, rx_frame);
            end
            rx_count = rx_count + 1;
        end
    endtask

    // all sampling on the falling edge, away from the dut updates
    always @(negedge clk_12_288) begin
        if (!reset_n) begin
            check_reset_outputs();
        end else begin
            cycle = cycle + 1;
            if (cycle == 0) begin
                check_reset_outputs();
                prev_sclk      = sclk;
                prev_lrclk     = lrclk;
                last_lr_toggle = 0;
                mclk_rises     = 0;
                print_result(T_RESET);
            end else begin
                check_clocks();
                check_serial();
                track_load();
                check_rx();
            end
            load_seen = tx_load;
        end
    end

    // fresh frame right after the dut took the previous one
    always @(posedge clk_12_288) begin
        if (load_seen) tx_frame <= i2s_pkg::i2s_frame_t'($random(seed));
    end

    initial begin
        int t;
        int total_checks;
        int total_errors;
        int tests_ok;
        int sva_fails;
        seed = 32'h4a65;
        tx_frame = i2s_pkg::i2s_frame_t'($random(seed));
        test_name = '{"reset_state", "clock_ratios", "load_spacing", "loopback", "serial_format"};
        for (t = 0; t < NUM_TESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        repeat (3) @(posedge clk_12_288);
        reset_n <= 1'b1;
        // first valid carries zeros, then one per looped frame
        wait (rx_count == NUM_FRAMES + 1);
        @(negedge clk_12_288);
        total_checks = 0;
        total_errors = 0;
        tests_ok = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            if (t != T_RESET) print_result(t);
            total_checks = total_checks + checks[t];
            total_errors = total_errors + errors[t];
            if (errors[t] == 0 && checks[t] > 0) tests_ok = tests_ok + 1;
        end
        sva_fails = dut.u_clk.u_checker.fail_count;
        $display("summary: %0d tests, %0d ok, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, tests_ok, total_checks, total_errors, sva_fails);
        if (tests_ok == NUM_TESTS && total_errors == 0 && sva_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
i2s_pkg.sv
i2s_clk.sv
i2s_tx.sv
i2s_rx.sv
i2s_top.sv
i2s_checker.sv
tb_i2s.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_i2s
FILE_LIST  := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := test passed
FAIL_MSG   := test failed
VFLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
# keep running after an assertion error so the testbench can report it
SIM_ARGS   := +verilator+error+limit+1000

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: all build run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

build: $(BUILD_DIR)/V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
